/* include/sifh_params.svh */
// sizes are fixed at compile time; NP must equal 2*NB and PIXEL_NUM must be at least 2
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// ******************************
// base sizes
// ******************************

// timestamp width, all-ones is the no-detection code
`define NP 8
// bin index width
`define NB 4
// pixels served in rotation
`define PIXEL_NUM 4
// samples per pixel per acquisition
`define DATA_NUM 2
// acquisitions per pass
`define ACQ_NUM 4
// bin counter width
`define PEAK_MAX 6

// ******************************
// derived values
// ******************************

// bins per histogram and fine window width
`define BIN_NUM (1 << `NB)
// pixel index width
`define PIX_W $clog2(`PIXEL_NUM)
// half window, the window sits SB below the coarse bin start
`define SB (1 << (`NB - 1))

`endif

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the verdict.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module sifhTb -Mdir obj_dir -o sifhSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sifhSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sources.f */
+incdir+include
src/sifhPkg.sv
src/passControl.sv
src/sampleFilter.sv
src/histogramBank.sv
src/peakTracker.sv
src/searchWindow.sv
src/sifhTop.sv
test/sifhTb.sv

/* src/histogramBank.sv */
// counters are PEAK_MAX bits wide and must never see more hits per bin than they can hold
`include "sifh_params.svh"

module histogramBank import sifhPkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  sampleT sample,
    input  logic   passEnd,
    output hitT    hit
);

    localparam int ENTRY_NUM = `PIXEL_NUM * `BIN_NUM;
    localparam int ADDR_W    = `PIX_W + `NB;

    // one histogram per pixel, pixel in the upper address bits
    logic [`PEAK_MAX-1:0] counters [ENTRY_NUM];
    // clear entries read as zero
    logic [ENTRY_NUM-1:0] validTbl;
    logic [ADDR_W-1:0]    rdAddr;
    logic [ADDR_W-1:0]    wrAddr;
    logic                 forward;
    logic [`PEAK_MAX-1:0] stored;
    logic [`PEAK_MAX-1:0] current;

    // ******************************
    // read side
    // ******************************

    assign rdAddr = {sample.pixel, sample.bin};
    assign wrAddr = {hit.pixel, hit.bin};

    // previous hit is written back one edge late
    assign forward = hit.valid && (wrAddr == rdAddr);
    assign stored  = validTbl[rdAddr] ? counters[rdAddr] : '0;
    assign current = forward ? hit.count : stored;

    // increment and present
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= '0;
        end else begin
            hit <= '{
                valid: sample.valid,
                pixel: sample.pixel,
                bin:   sample.bin,
                count: current + 1'b1
            };
        end
    end

    // ******************************
    // write back and clear
    // ******************************

    always_ff @(posedge clk) begin
        if (hit.valid) begin
            counters[wrAddr] <= hit.count;
        end
    end

    // whole table cleared in one cycle at the end of a pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validTbl <= '0;
        end else if (passEnd) begin
            validTbl <= '0;
        end else if (hit.valid) begin
            validTbl[wrAddr] <= 1'b1;
        end
    end

    // an accepted sample never finds its counter already full
    assert property (@(posedge clk) disable iff (!combin_res)
        sample.valid |-> (current != '1));

endmodule

/* src/passControl.sv */
// no back-pressure; wrEn must stay low from the last sample of a pass until busy falls
`include "sifh_params.svh"

module passControl import sifhPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    output logic [`PIX_W-1:0] pixel,
    output passT              pass,
    output logic              passEnd,
    output logic              busy
);

    // counter widths, kept at least one bit
    localparam int SAMPLE_W = (`DATA_NUM > 1) ? $clog2(`DATA_NUM) : 1;
    localparam int ACQ_W    = (`ACQ_NUM > 1) ? $clog2(`ACQ_NUM) : 1;

    logic [SAMPLE_W-1:0] sampleCnt;
    logic [`PIX_W-1:0]   pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;
    logic                sampleWrap;
    logic                pixelWrap;
    logic                acqWrap;
    logic                lastSample;
    // one bit per pipeline stage still draining
    logic [2:0]          flush;

    // ******************************
    // rotation counters
    // ******************************

    assign sampleWrap = (sampleCnt == SAMPLE_W'(`DATA_NUM - 1));
    assign pixelWrap  = (pixelCnt == `PIX_W'(`PIXEL_NUM - 1));
    assign acqWrap    = (acqCnt == ACQ_W'(`ACQ_NUM - 1));

    // strobe that closes the pass
    assign lastSample = wrEn && sampleWrap && pixelWrap && acqWrap;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (wrEn) begin
            if (sampleWrap) begin
                sampleCnt <= '0;
                // next pixel after DATA_NUM samples
                if (pixelWrap) begin
                    pixelCnt <= '0;
                    acqCnt   <= acqWrap ? '0 : acqCnt + 1'b1;
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // pixel of the sample now at the input
    assign pixel = pixelCnt;

    // ******************************
    // end of pass sequencing
    // ******************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            flush <= '0;
            pass  <= COARSE;
        end else begin
            // filter, bank, tracker stages
            flush <= {flush[1:0], lastSample};
            if (passEnd) begin
                pass <= (pass == COARSE) ? FINE : COARSE;
            end
        end
    end

    // last item has left the peak tracker
    assign passEnd = flush[2];
    assign busy    = |flush;

    // no strobe while the flush is draining
    assert property (@(posedge clk) disable iff (!combin_res)
        wrEn |-> !busy);

    // pass end is a single pulse
    assert property (@(posedge clk) disable iff (!combin_res)
        passEnd |=> !passEnd);

endmodule

/* src/peakTracker.sv */
// ties keep the first bin to reach a count; peaks are zeroed on every pass end
`include "sifh_params.svh"

module peakTracker import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  combin_res,
    input  hitT                   hit,
    input  logic                  passEnd,
    output peakT [`PIXEL_NUM-1:0] peaks
);

    // stored peak of the pixel under the current hit
    peakT held;
    // hit beats the stored maximum
    logic better;

    // ******************************
    // compare
    // ******************************

    always_comb begin
        held = peaks[hit.pixel];
        // strictly greater, so an equal count never moves the peak
        better = hit.valid && (hit.count > held.count);
    end

    // ******************************
    // peak storage
    // ******************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peaks <= '0;
        end else if (passEnd) begin
            // window and result logic sample the peaks on this same edge
            peaks <= '0;
        end else if (better) begin
            peaks[hit.pixel] <= '{
                bin:   hit.bin,
                count: hit.count
            };
        end
    end

endmodule

/* src/sampleFilter.sv */
// fine-pass windows must stay inside the timestamp range; all-ones data is never counted
`include "sifh_params.svh"

module sampleFilter import sifhPkg::*; (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    wrEn,
    input  logic [`NP-1:0]          data,
    input  logic [`PIX_W-1:0]       pixel,
    input  passT                    pass,
    input  windowT [`PIXEL_NUM-1:0] windows,
    output sampleT                  sample
);

    logic [`NP-1:0] offset;
    logic [`NB-1:0] nextBin;
    logic           noDetect;
    logic           inRange;

    // ******************************
    // bin selection
    // ******************************

    always_comb begin
        // distance from the window low, wraps high when below it
        offset   = data - windows[pixel];
        noDetect = &data;
        if (pass == COARSE) begin
            // top bits only
            nextBin = data[`NP-1 -: `NB];
            inRange = 1'b1;
        end else begin
            nextBin = offset[`NB-1:0];
            // outside the window is dropped
            inRange = (offset < `BIN_NUM);
        end
    end

    // ******************************
    // output register
    // ******************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sample <= '0;
        end else begin
            sample <= '{
                valid: wrEn && !noDetect && inRange,
                pixel: pixel,
                bin:   nextBin
            };
        end
    end

endmodule

/* src/searchWindow.sv */
// the window upper clamp keeps every fine window inside the timestamp range
`include "sifh_params.svh"

module searchWindow import sifhPkg::*; (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    passEnd,
    input  passT                    pass,
    input  peakT   [`PIXEL_NUM-1:0] peaks,
    output windowT [`PIXEL_NUM-1:0] windows,
    output resultT [`PIXEL_NUM-1:0] result,
    output logic                    resultValid
);

    // highest legal window low, one bit wider for the compare
    localparam logic [`NP:0] LOW_MAX = (1 << `NP) - `BIN_NUM;
    localparam logic [`NP:0] HALF    = `SB;

    // ******************************
    // window rule
    // ******************************

    function automatic windowT clampLow(input logic [`NB-1:0] bin);
        logic [`NP:0] start;
        logic [`NP:0] low;
        // first timestamp of the coarse bin
        start = {1'b0, bin, {(`NP - `NB){1'b0}}};
        low   = start - HALF;
        if (start < HALF) begin
            return '0;
        end else if (low > LOW_MAX) begin
            return LOW_MAX[`NP-1:0];
        end
        return low[`NP-1:0];
    endfunction

    // coarse pass end loads windows, fine pass end flags results
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows     <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= passEnd && (pass == FINE);
            if (passEnd && (pass == COARSE)) begin
                for (int p = 0; p < `PIXEL_NUM; p++) begin
                    // empty histogram keeps the window at zero
                    windows[p] <= (peaks[p].count == '0) ? '0 : clampLow(peaks[p].bin);
                end
            end
        end
    end

    // ******************************
    // result assembly
    // ******************************

    always_ff @(posedge clk) begin
        if (passEnd && (pass == FINE)) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                // fine bin is relative to the window low
                result[p] <= (peaks[p].count == '0) ? windows[p] :
                             windows[p] + {{(`NP - `NB){1'b0}}, peaks[p].bin};
            end
        end
    end

endmodule

/* src/sifhPkg.sv */
// shared types only; every width here comes from the params header
`include "sifh_params.svh"

package sifhPkg;

    // ******************************
    // pass state
    // ******************************

    // coarse builds the window, fine builds the result
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

    // ******************************
    // datapath records
    // ******************************

    // filter output, bin already relative to the window in the fine pass
    typedef struct packed {
        logic              valid;
        logic [`PIX_W-1:0] pixel;
        logic [`NB-1:0]    bin;
    } sampleT;

    // histogram output, count is the value after the increment
    typedef struct packed {
        logic                 valid;
        logic [`PIX_W-1:0]    pixel;
        logic [`NB-1:0]       bin;
        logic [`PEAK_MAX-1:0] count;
    } hitT;

    // window low bound of one pixel
    typedef logic [`NP-1:0] windowT;

    // running peak of one pixel
    typedef struct packed {
        logic [`NB-1:0]       bin;
        logic [`PEAK_MAX-1:0] count;
    } peakT;

    // final timestamp of one pixel
    typedef logic [`NP-1:0] resultT;

endpackage

/* src/sifhTop.sv */
// results are only meaningful during the resultValid pulse; see passControl for strobe limits
`include "sifh_params.svh"

module sifhTop (
    input  logic                             clk,
    input  logic                             combin_res,
    input  logic                             wrEn,
    input  logic [`NP-1:0]                   data,
    output logic                             busy,
    output logic                             resultValid,
    output sifhPkg::resultT [`PIXEL_NUM-1:0] result,
    output sifhPkg::passT                    pass
);

    // ******************************
    // internal wires
    // ******************************

    logic [`PIX_W-1:0]                pixel;
    logic                             passEnd;
    sifhPkg::sampleT                  sample;
    sifhPkg::hitT                     hit;
    sifhPkg::peakT   [`PIXEL_NUM-1:0] peaks;
    // fed back from the window logic to the filter
    sifhPkg::windowT [`PIXEL_NUM-1:0] windows;

    // counters, pass state, flush
    passControl passControl_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .pixel      (pixel),
        .pass       (pass),
        .passEnd    (passEnd),
        .busy       (busy)
    );

    // ******************************
    // datapath chain
    // ******************************

    sampleFilter sampleFilter_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .pixel      (pixel),
        .pass       (pass),
        .windows    (windows),
        .sample     (sample)
    );

    histogramBank histogramBank_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .sample     (sample),
        .passEnd    (passEnd),
        .hit        (hit)
    );

    peakTracker peakTracker_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .passEnd    (passEnd),
        .peaks      (peaks)
    );

    // window load after coarse, results after fine
    searchWindow searchWindow_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .passEnd     (passEnd),
        .pass        (pass),
        .peaks       (peaks),
        .windows     (windows),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

/* test/sifhTb.sv */
// directed rows assume 8-bit timestamps and 8 samples per pixel per pass; combin_res is active low
`include "sifh_params.svh"

module sifhTb import sifhPkg::*; ();

    // ******************************
    // sizes and limits
    // ******************************

    localparam int SAMPLES_PIX  = `DATA_NUM * `ACQ_NUM;
    localparam int PASS_SAMPLES = SAMPLES_PIX * `PIXEL_NUM;
    localparam int ALL_ONES     = (1 << `NP) - 1;
    localparam int DIRECT_ROWS  = 3;
    localparam int ROWS         = DIRECT_ROWS + 6;
    // two passes, a gap every third sample, flush and pulse
    localparam int FRAME_CYCLES = 2 * (PASS_SAMPLES + PASS_SAMPLES / 3 + 8);
    localparam int CYCLE_LIMIT  = 8 + ROWS * FRAME_CYCLES + 100;

    logic                    clk;
    logic                    combin_res;
    logic                    wrEn;
    logic [`NP-1:0]          data;
    logic                    busy;
    logic                    resultValid;
    resultT [`PIXEL_NUM-1:0] result;
    passT                    pass;

    // row, pass (0 coarse, 1 fine), pixel, sample slot
    logic [`NP-1:0] stimTbl [ROWS][2][`PIXEL_NUM][SAMPLES_PIX];
    // idle gaps per row
    logic           gapTbl [ROWS];
    // expected result per row and pixel
    int             expTbl [ROWS][`PIXEL_NUM];
    integer         seed;
    int             errorCount;
    int             checkCount;
    int             cycleCount;

    sifhTop sifhTop_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result),
        .pass        (pass)
    );

    // 40 unit period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // hard stop on a stuck run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare(input int got, input int exp, input string msg);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // ******************************
    // reference model
    // ******************************

    // peak of one pixel's samples in one pass, strictly greater wins
    task automatic peakOf(input int row, input int ps, input int pix, input int low,
                          output int bin, output int cnt);
        int hist [`BIN_NUM];
        int v;
        int b;
        bin = 0;
        cnt = 0;
        foreach (hist[i]) hist[i] = 0;
        for (int k = 0; k < SAMPLES_PIX; k++) begin
            v = stimTbl[row][ps][pix][k];
            // no detection
            if (v == ALL_ONES) continue;
            if (ps == 0) begin
                b = v >> (`NP - `NB);
            end else begin
                // outside the window
                if (v < low || v - low >= `BIN_NUM) continue;
                b = v - low;
            end
            hist[b]++;
            if (hist[b] > cnt) begin
                cnt = hist[b];
                bin = b;
            end
        end
    endtask

    // coarse bin start minus half a window, clamped to the timestamp range
    function automatic int windowLow(input int bin, input int cnt);
        int w;
        if (cnt == 0) return 0;
        w = (bin << (`NP - `NB)) - `SB;
        if (w < 0) w = 0;
        if (w > (1 << `NP) - `BIN_NUM) w = (1 << `NP) - `BIN_NUM;
        return w;
    endfunction

    task automatic model(input int row);
        int bin;
        int cnt;
        int low;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            peakOf(row, 0, p, 0, bin, cnt);
            low = windowLow(bin, cnt);
            peakOf(row, 1, p, low, bin, cnt);
            // empty fine histogram reports the window low
            expTbl[row][p] = (cnt == 0) ? low : low + bin;
        end
    endtask

    // ******************************
    // stimulus table
    // ******************************

    // first byte of each literal is the first sample
    task automatic setPixel(input int row, input int pix, input logic [63:0] coarse,
                            input logic [63:0] fine);
        for (int k = 0; k < SAMPLES_PIX; k++) begin
            stimTbl[row][0][pix][k] = coarse[63 - 8 * k -: 8];
            stimTbl[row][1][pix][k] = fine[63 - 8 * k -: 8];
        end
    endtask

    // one cluster per pixel, a few no-detection and stray samples
    task automatic fillRandom(input int row);
        int center;
        int v;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            center = $random(seed) & ALL_ONES;
            for (int ps = 0; ps < 2; ps++) begin
                for (int k = 0; k < SAMPLES_PIX; k++) begin
                    v = center + $random(seed) % 6;
                    if (($random(seed) & 15) == 0) begin
                        v = ALL_ONES;
                    end else if (ps == 1 && ($random(seed) & 7) == 0) begin
                        v = $random(seed);
                    end
                    stimTbl[row][ps][p][k] = v[`NP-1:0];
                end
            end
        end
        gapTbl[row] = $random(seed) & 1;
    endtask

    task automatic buildTable();
        // one coarse bin per pixel, pixel 0 hits the low clamp
        setPixel(0, 0, 64'h05_06_03_05_07_01_05_02, 64'h05_05_06_05_02_05_0E_03);
        setPixel(0, 1, 64'h47_4A_41_4C_43_4F_40_48, 64'h42_42_3A_42_47_42_39_40);
        setPixel(0, 2, 64'h91_95_9A_93_9F_90_98_96, 64'h8C_8C_8C_95_90_8C_97_88);
        setPixel(0, 3, 64'hF0_F3_F5_FE_F1_F9_F2_F7, 64'hF4_F4_E9_F4_F6_F4_F7_F4);
        gapTbl[0] = 1'b1;
        // out of window and no-detection samples
        setPixel(1, 0, 64'h25_27_FF_22_FF_2A_21_2F, 64'hFF_17_28_28_FF_30_28_1A);
        setPixel(1, 1, 64'hFF_FF_FF_FF_FF_FF_FF_FF, 64'hFF_FF_03_FF_20_FF_03_FF);
        setPixel(1, 2, 64'hFF_FF_FF_FF_FF_FF_FF_FF, 64'hFF_FF_FF_FF_FF_FF_FF_FF);
        setPixel(1, 3, 64'h63_65_FF_66_61_FF_6E_60, 64'h57_68_5A_5A_FF_67_5A_68);
        gapTbl[1] = 1'b1;
        // ties, and back-to-back hits with no gaps
        setPixel(2, 0, 64'h31_51_51_31_FF_FF_FF_FF, 64'h50_50_52_52_52_50_FF_FF);
        setPixel(2, 1, 64'h11_11_11_11_11_11_11_11, 64'h0C_0C_0C_0C_0C_0C_0C_0C);
        setPixel(2, 2, 64'hA2_A2_A2_FF_FF_FF_FF_FF, 64'h9A_A0_A0_9A_FF_FF_FF_FF);
        setPixel(2, 3, 64'hC0_C0_D0_D0_E0_E0_FF_FF, 64'hC0_C1_C1_C0_B8_B8_FF_FF);
        gapTbl[2] = 1'b0;
        for (int row = DIRECT_ROWS; row < ROWS; row++) begin
            fillRandom(row);
        end
        for (int row = 0; row < ROWS; row++) begin
            model(row);
        end
    endtask

    // ******************************
    // drive and check
    // ******************************

    // pixel rotation order, acquisition outermost
    task automatic stream(input int row, input int ps);
        int n;
        n = 0;
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                for (int s = 0; s < `DATA_NUM; s++) begin
                    @(posedge clk);
                    wrEn <= 1'b1;
                    data <= stimTbl[row][ps][p][a * `DATA_NUM + s];
                    n++;
                    if (gapTbl[row] && (n % 3 == 0) && (n < PASS_SAMPLES)) begin
                        @(posedge clk);
                        wrEn <= 1'b0;
                        data <= '1;
                    end
                end
            end
        end
        // this edge samples the last strobe
        @(posedge clk);
        wrEn <= 1'b0;
        data <= '0;
    endtask

    // busy spans three drain cycles, then a one-cycle resultValid on a fine pass
    task automatic waitFlush(input int row, input bit finePass);
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            compare(resultValid, 0, "resultValid during flush");
            n++;
            @(negedge clk);
        end
        compare(n, 3, "busy cycles after the last strobe");
        compare(resultValid, finePass, "resultValid after flush");
        compare(pass, finePass ? COARSE : FINE, "pass after flush");
        if (finePass) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                compare(result[p], expTbl[row][p],
                        $sformatf("row %0d pixel %0d result", row, p));
            end
        end
        @(negedge clk);
        compare(resultValid, 0, "resultValid pulse width");
    endtask

    initial begin
        seed = 24;
        errorCount = 0;
        checkCount = 0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        buildTable();
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        // idle state before any strobe
        @(negedge clk);
        compare(busy, 0, "busy after reset");
        compare(resultValid, 0, "resultValid after reset");
        compare(pass, COARSE, "pass after reset");
        for (int row = 0; row < ROWS; row++) begin
            stream(row, 0);
            waitFlush(row, 1'b0);
            stream(row, 1);
            waitFlush(row, 1'b1);
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
